//--- verilog/fx_pkg.sv
package fx_pkg;

    localparam int Q_INT  = 16;                 // integer bits, sign included
    localparam int Q_FRAC = 16;
    localparam int FX_W   = Q_INT + Q_FRAC;

    typedef logic signed [FX_W-1:0]   fx_t;     // one Q16.16 value
    typedef logic signed [2*FX_W-1:0] fx_dbl_t; // full product / widened dividend

    localparam fx_t FX_MAX = {1'b0, {(FX_W-1){1'b1}}};
    localparam fx_t FX_MIN = {1'b1, {(FX_W-1){1'b0}}};

    typedef enum logic [1:0] {
        FX_ADD = 2'd0,
        FX_SUB = 2'd1,
        FX_MUL = 2'd2,
        FX_DIV = 2'd3
    } fx_op_e;

    typedef struct packed {
        fx_op_e op;
        fx_t    a;
        fx_t    b;
    } fx_req_t;

    typedef struct packed {
        logic overflow;                         // result was clamped
        logic div_zero;                         // divisor was zero
    } fx_flags_t;

    typedef struct packed {
        fx_t       result;
        fx_flags_t flags;
    } fx_rsp_t;

    typedef struct packed {
        logic addsub;
        logic mul;
        logic div;
    } fx_start_t;

    localparam int UNIT_LATENCY = 4;            // start to done, every unit
    localparam int DIV_PIPE     = 2;            // quotient stages in the divider
    localparam int FX_LATENCY   = UNIT_LATENCY + 2;

endpackage

//--- verilog/fx_issue.sv
module fx_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  fx_pkg::fx_req_t   req,
    output fx_pkg::fx_start_t start,
    output logic              op_sub,
    output fx_pkg::fx_t       a,
    output fx_pkg::fx_t       b
);
    import fx_pkg::*;

    fx_start_t start_nxt;

    // one start bit per request, add and sub share a unit
    always_comb begin
        start_nxt = '0;
        if (req_valid) begin
            unique case (req.op)
                FX_ADD,
                FX_SUB:  start_nxt.addsub = 1'b1;
                FX_MUL:  start_nxt.mul    = 1'b1;
                FX_DIV:  start_nxt.div    = 1'b1;
                default: start_nxt        = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start <= '0;
        end else begin
            start <= start_nxt;
        end
    end

    // operands only move when a request comes in
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_sub <= 1'b0;
            a      <= '0;
            b      <= '0;
        end else if (req_valid) begin
            op_sub <= (req.op == FX_SUB);
            a      <= req.a;
            b      <= req.b;
        end
    end

    // every request goes to exactly one unit
    a_start_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        req_valid |=> $onehot(start)
    ) else $error("fx_issue: request without exactly one start pulse");

endmodule

//--- verilog/fx_addsub.sv
module fx_addsub (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              op_sub,
    input  fx_pkg::fx_t       a,
    input  fx_pkg::fx_t       b,
    output logic              done,
    output fx_pkg::fx_t       result,
    output fx_pkg::fx_flags_t flags
);
    import fx_pkg::*;

    logic signed [FX_W:0]          sum;       // one guard bit above the sign
    fx_rsp_t                       sat;
    fx_rsp_t [UNIT_LATENCY-1:0]    pipe;      // value and flags, oldest at top
    logic    [UNIT_LATENCY-1:0]    start_dl;

    always_comb begin
        // operands sign extend to the 33-bit context
        sum = op_sub ? (a - b) : (a + b);

        sat.flags.div_zero = 1'b0;
        sat.flags.overflow = sum[FX_W] ^ sum[FX_W-1];   // guard and sign disagree
        if (!sat.flags.overflow) begin
            sat.result = sum[FX_W-1:0];
        end else if (sum[FX_W]) begin
            sat.result = FX_MIN;                        // negative overflow
        end else begin
            sat.result = FX_MAX;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pipe <= '0;
        end else begin
            pipe <= {pipe[UNIT_LATENCY-2:0], sat};
        end
    end

    // done follows start through the same number of stages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_dl <= '0;
        end else begin
            start_dl <= {start_dl[UNIT_LATENCY-2:0], start};
        end
    end

    assign done   = start_dl[UNIT_LATENCY-1];
    assign result = pipe[UNIT_LATENCY-1].result;
    assign flags  = pipe[UNIT_LATENCY-1].flags;

endmodule

//--- verilog/fx_mul.sv
module fx_mul (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  fx_pkg::fx_t       a,
    input  fx_pkg::fx_t       b,
    output logic              done,
    output fx_pkg::fx_t       result,
    output fx_pkg::fx_flags_t flags
);
    import fx_pkg::*;

    fx_t                       a_q;
    fx_t                       b_q;
    fx_dbl_t                   prod;        // full 64-bit product
    fx_dbl_t                   shifted;
    fx_rsp_t                   sat;
    fx_rsp_t                   sat_q;
    fx_rsp_t                   out_q;
    logic [UNIT_LATENCY-1:0]   start_dl;

    always_comb begin
        shifted = prod >>> Q_FRAC;          // drop fraction bits, truncate
        sat.flags.div_zero = 1'b0;
        sat.flags.overflow = 1'b0;
        sat.result         = shifted[FX_W-1:0];
        if (shifted > FX_MAX) begin
            sat.result         = FX_MAX;
            sat.flags.overflow = 1'b1;
        end else if (shifted < FX_MIN) begin
            sat.result         = FX_MIN;
            sat.flags.overflow = 1'b1;
        end
    end

    // operand reg, product, saturate, output
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_q   <= '0;
            b_q   <= '0;
            prod  <= '0;
            sat_q <= '0;
            out_q <= '0;
        end else begin
            a_q   <= a;
            b_q   <= b;
            prod  <= fx_dbl_t'(a_q) * fx_dbl_t'(b_q);
            sat_q <= sat;
            out_q <= sat_q;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_dl <= '0;
        end else begin
            start_dl <= {start_dl[UNIT_LATENCY-2:0], start};
        end
    end

    assign done   = start_dl[UNIT_LATENCY-1];
    assign result = out_q.result;
    assign flags  = out_q.flags;

    // a zero operand comes out as a clean zero, lined up with done
    a_no_div_zero: assert property (
        @(posedge clk) disable iff (!rst)
        start && (a == '0 || b == '0) |->
            ##UNIT_LATENCY (done && result == '0 && flags == '0)
    ) else $error("fx_mul: zero operand did not give a clean zero with done");

endmodule

//--- verilog/fx_div.sv
module fx_div (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  fx_pkg::fx_t       numerator,
    input  fx_pkg::fx_t       denominator,
    output logic              done,
    output fx_pkg::fx_t       result,
    output fx_pkg::fx_flags_t flags
);
    import fx_pkg::*;

    typedef struct packed {
        fx_t  quot;                  // low word of the quotient
        logic hi;                    // clamp to FX_MAX
        logic lo;                    // clamp to FX_MIN
        logic dz;
    } div_stage_t;

    fx_t                          num_q;
    fx_t                          den_q;
    fx_dbl_t                      dividend;
    fx_dbl_t                      divisor;
    fx_dbl_t                      quotient;
    div_stage_t                   head;
    div_stage_t [DIV_PIPE-1:0]    pipe;
    div_stage_t                   tail;
    logic [UNIT_LATENCY-1:0]      start_dl;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            num_q <= '0;
            den_q <= '0;
        end else begin
            num_q <= numerator;
            den_q <= denominator;
        end
    end

    always_comb begin
        dividend = fx_dbl_t'(num_q) <<< Q_FRAC;
        // keep the divider defined, the zero case is replaced later
        divisor  = (den_q == '0) ? fx_dbl_t'(1) : fx_dbl_t'(den_q);
        quotient = dividend / divisor;      // truncates toward zero

        head.quot = quotient[FX_W-1:0];
        head.dz   = (den_q == '0);
        head.hi   = head.dz ? !num_q[FX_W-1] : (quotient > FX_MAX);
        head.lo   = head.dz ?  num_q[FX_W-1] : (quotient < FX_MIN);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pipe <= '0;
        end else begin
            pipe[0] <= head;
            for (int i = 1; i < DIV_PIPE; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign tail = pipe[DIV_PIPE-1];

    // saturation and zero-divisor substitution at the output register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result <= '0;
            flags  <= '0;
        end else begin
            if (tail.hi) begin
                result <= FX_MAX;
            end else if (tail.lo) begin
                result <= FX_MIN;
            end else begin
                result <= tail.quot;
            end
            flags.overflow <= tail.hi | tail.lo;
            flags.div_zero <= tail.dz;
        end
    end

    // one bit per cycle in flight
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_dl <= '0;
        end else begin
            start_dl <= {start_dl[UNIT_LATENCY-2:0], start};
        end
    end

    assign done = start_dl[UNIT_LATENCY-1];

    // operand reg + quotient stages + output reg must match the delay line
    a_done_latency: assert property (
        @(posedge clk) disable iff (!rst)
        start |-> ##UNIT_LATENCY
            (done && (flags.div_zero == $past(denominator == '0, UNIT_LATENCY)))
    ) else $error("fx_div: done or div_zero out of step with start after %0d cycles",
                  UNIT_LATENCY);

endmodule

//--- verilog/fx_merge.sv
module fx_merge (
    input  logic              clk,
    input  logic              rst,
    input  logic              add_done,
    input  fx_pkg::fx_t       add_result,
    input  fx_pkg::fx_flags_t add_flags,
    input  logic              mul_done,
    input  fx_pkg::fx_t       mul_result,
    input  fx_pkg::fx_flags_t mul_flags,
    input  logic              div_done,
    input  fx_pkg::fx_t       div_result,
    input  fx_pkg::fx_flags_t div_flags,
    output logic              rsp_valid,
    output fx_pkg::fx_rsp_t   rsp
);
    import fx_pkg::*;

    logic    any_done;
    fx_rsp_t sel;

    // equal latencies mean at most one unit finishes per cycle
    always_comb begin
        any_done = add_done | mul_done | div_done;
        sel      = '{result: add_result, flags: add_flags};
        if (mul_done) begin
            sel = '{result: mul_result, flags: mul_flags};
        end else if (div_done) begin
            sel = '{result: div_result, flags: div_flags};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= any_done;
            if (any_done) begin
                rsp <= sel;                 // holds between pulses
            end
        end
    end

    a_done_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0({add_done, mul_done, div_done})
    ) else $error("fx_merge: two units done in one cycle");

endmodule

//--- verilog/fx_unit.sv
module fx_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  fx_pkg::fx_req_t req,
    output logic            rsp_valid,
    output fx_pkg::fx_rsp_t rsp
);
    import fx_pkg::*;

    fx_start_t start;
    logic      op_sub;
    fx_t       a;
    fx_t       b;

    logic      add_done;
    fx_t       add_result;
    fx_flags_t add_flags;
    logic      mul_done;
    fx_t       mul_result;
    fx_flags_t mul_flags;
    logic      div_done;
    fx_t       div_result;
    fx_flags_t div_flags;

    fx_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .start     (start),
        .op_sub    (op_sub),
        .a         (a),
        .b         (b)
    );

    fx_addsub u_addsub (
        .clk    (clk),
        .rst    (rst),
        .start  (start.addsub),
        .op_sub (op_sub),
        .a      (a),
        .b      (b),
        .done   (add_done),
        .result (add_result),
        .flags  (add_flags)
    );

    fx_mul u_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (start.mul),
        .a      (a),
        .b      (b),
        .done   (mul_done),
        .result (mul_result),
        .flags  (mul_flags)
    );

    fx_div u_div (
        .clk         (clk),
        .rst         (rst),
        .start       (start.div),
        .numerator   (a),
        .denominator (b),
        .done        (div_done),
        .result      (div_result),
        .flags       (div_flags)
    );

    fx_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .add_done   (add_done),
        .add_result (add_result),
        .add_flags  (add_flags),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_flags  (mul_flags),
        .div_done   (div_done),
        .div_result (div_result),
        .div_flags  (div_flags),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

//--- tb/tb_fx_unit.sv
module tb_fx_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import fx_pkg::*;

    localparam int BASIC_REQ   = 4;
    localparam int SAT_REQ     = 8;
    localparam int DZ_REQ      = 2;
    localparam int STREAM_REQ  = 200;
    localparam int SPARSE_REQ  = 60;
    localparam int MAX_GAP     = 7;
    localparam int DRAIN_SLACK = 8;             // extra cycles allowed past the latency
    localparam int NUM_TESTS   = 6;
    localparam int TOTAL_REQ   = BASIC_REQ + SAT_REQ + DZ_REQ + STREAM_REQ + SPARSE_REQ;
    localparam int WATCHDOG_CYCLES = TOTAL_REQ + SPARSE_REQ * MAX_GAP + FX_LATENCY
                                   + NUM_TESTS * (FX_LATENCY + DRAIN_SLACK + 1) + 40;

    localparam fx_flags_t NO_FLAGS = '{overflow: 1'b0, div_zero: 1'b0};
    localparam fx_flags_t OVF      = '{overflow: 1'b1, div_zero: 1'b0};
    localparam fx_flags_t DZ_OVF   = '{overflow: 1'b1, div_zero: 1'b1};

    typedef struct packed {
        fx_op_e      op;
        fx_rsp_t     rsp;                       // expected response
        logic [31:0] cyc;                       // cycle count at issue
    } pending_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    fx_req_t     req;
    logic        rsp_valid;
    fx_rsp_t     rsp;

    pending_t    pending[$];
    pending_t    head_p;
    logic [31:0] cycle_cnt;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          rsp_count;

    fx_unit uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic fx_rsp_t rsp_of(input fx_t value, input fx_flags_t f);
        fx_rsp_t r;
        r.result = value;
        r.flags  = f;
        return r;
    endfunction

    // reference arithmetic on 64-bit integers
    function automatic fx_rsp_t model(input fx_op_e op, input fx_t a, input fx_t b);
        longint  exact;
        fx_rsp_t r;
        r = '0;
        case (op)
            FX_ADD:  exact = longint'(a) + longint'(b);
            FX_SUB:  exact = longint'(a) - longint'(b);
            FX_MUL:  exact = (longint'(a) * longint'(b)) >>> Q_FRAC;
            default: begin
                if (b == 0) begin
                    return rsp_of((a < 0) ? FX_MIN : FX_MAX, DZ_OVF);
                end
                exact = (longint'(a) * (longint'(1) << Q_FRAC)) / longint'(b);
            end
        endcase
        if (exact > longint'(FX_MAX)) begin
            r = rsp_of(FX_MAX, OVF);
        end else if (exact < longint'(FX_MIN)) begin
            r = rsp_of(FX_MIN, OVF);
        end else begin
            r = rsp_of(fx_t'(exact), NO_FLAGS);
        end
        return r;
    endfunction

    task automatic check_result(input fx_t got, input fx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s result %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input fx_flags_t got, input fx_flags_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s flags %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // response monitor, reads outputs before this edge updates them
    always @(posedge clk) begin
        if (rst && rsp_valid) begin
            rsp_count++;
            if (pending.size() == 0) begin
                $display("unexpected response at %0t: rsp_valid high with no request pending",
                         $time);
                errors++;
            end else begin
                head_p = pending.pop_front();
                check_result(rsp.result, head_p.rsp.result, head_p.op.name());
                check_flags(rsp.flags, head_p.rsp.flags, head_p.op.name());
                checks++;
                if (cycle_cnt - head_p.cyc != FX_LATENCY) begin
                    $display("ERR %0t: %s response after %0d cycles, expected %0d", $time,
                             head_p.op.name(), cycle_cnt - head_p.cyc, FX_LATENCY);
                    errors++;
                end
            end
        end
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic drive(input fx_op_e op, input fx_t a, input fx_t b, input fx_rsp_t exp);
        pending_t p;
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = op;
        req.a     = a;
        req.b     = b;
        p.op      = op;
        p.rsp     = exp;
        p.cyc     = cycle_cnt;
        pending.push_back(p);
    endtask

    task automatic send_model(input fx_op_e op, input fx_t a, input fx_t b);
        drive(op, a, b, model(op, a, b));
    endtask

    task automatic send_random();
        logic [31:0] r;
        fx_t         a;
        fx_t         b;
        r = next_random();
        a = fx_t'(next_random()) >>> (next_random() % 24);    // spread of magnitudes
        b = fx_t'(next_random()) >>> (next_random() % 24);
        if (r[7:4] == 4'd0) begin
            b = '0;                                           // occasional zero divisor
        end
        send_model(fx_op_e'(r[1:0]), a, b);
    endtask

    task automatic pause(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (pending.size() != 0 && waited < FX_LATENCY + DRAIN_SLACK) begin
            @(negedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            $display("missing response: %0d request(s) were never answered", pending.size());
            errors++;
            pending.delete();
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %-12s done, %0d error(s)", name, errors - err_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            check_result(rsp.result, '0, "idle after reset");
            check_flags(rsp.flags, NO_FLAGS, "idle after reset");
        end
        if (rsp_count != 0) begin
            $display("response seen after reset although no request was sent");
            errors++;
        end
        report_test("reset", e0);
    endtask

    task automatic test_basic();
        int e0;
        e0 = errors;
        send_model(FX_ADD, 32'h0001_8000, 32'h0002_4000);      // 1.5 + 2.25
        send_model(FX_SUB, 32'h0001_8000, 32'h0002_4000);
        send_model(FX_MUL, 32'h0001_8000, 32'hFFFE_0000);      // 1.5 * -2.0
        send_model(FX_DIV, 32'h0003_8000, 32'h0001_4000);      // 3.5 / 1.25
        wait_drain();
        report_test("basic", e0);
    endtask

    task automatic test_saturation();
        int e0;
        e0 = errors;
        drive(FX_ADD, FX_MAX, 32'h0001_0000, rsp_of(FX_MAX, OVF));
        drive(FX_ADD, FX_MIN, 32'hFFFF_0000, rsp_of(FX_MIN, OVF));
        drive(FX_SUB, FX_MIN, 32'h0001_0000, rsp_of(FX_MIN, OVF));
        drive(FX_SUB, FX_MAX, 32'hFFFF_0000, rsp_of(FX_MAX, OVF));
        drive(FX_MUL, 32'h012C_0000, 32'h012C_0000, rsp_of(FX_MAX, OVF));   // 300 * 300
        drive(FX_MUL, 32'h012C_0000, 32'hFED4_0000, rsp_of(FX_MIN, OVF));
        drive(FX_DIV, 32'h0002_0000, 32'h0000_0001, rsp_of(FX_MAX, OVF));   // 2 / lsb
        drive(FX_DIV, 32'hFFFE_0000, 32'h0000_0001, rsp_of(FX_MIN, OVF));
        wait_drain();
        report_test("saturation", e0);
    endtask

    task automatic test_div_zero();
        int e0;
        e0 = errors;
        drive(FX_DIV, 32'h0003_8000, 32'h0000_0000, rsp_of(FX_MAX, DZ_OVF));
        drive(FX_DIV, 32'hFFFE_0000, 32'h0000_0000, rsp_of(FX_MIN, DZ_OVF));
        wait_drain();
        report_test("div_zero", e0);
    endtask

    task automatic test_stream();
        int e0;
        e0 = errors;
        repeat (STREAM_REQ) begin
            send_random();
        end
        wait_drain();
        report_test("stream", e0);
    endtask

    task automatic test_sparse();
        int e0;
        e0 = errors;
        repeat (SPARSE_REQ) begin
            send_random();
            pause(next_random() % (MAX_GAP + 1));
        end
        wait_drain();
        report_test("sparse", e0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        cycle_cnt = '0;
        rng_state = 32'h7908;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        rsp_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_reset();
        test_basic();
        test_saturation();
        test_div_zero();
        test_stream();
        test_sparse();

        $display("tests %0d, checks %0d, responses %0d, errors %0d",
                 tests_run, checks, rsp_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/fx_pkg.sv
verilog/fx_issue.sv
verilog/fx_addsub.sv
verilog/fx_mul.sv
verilog/fx_div.sv
verilog/fx_merge.sv
verilog/fx_unit.sv
tb/tb_fx_unit.sv
